// File: cmd_pkg.sv
// Shared definitions for the command engine: command word views, operation codes
// and the bit layout of the result word. Imported by every stage and the top level.
package cmd_pkg;

    // word sizes
    localparam int unsigned CmdWidth   = 16;
    localparam int unsigned ValueWidth = 16;
    localparam int unsigned TagWidth   = 4;
    localparam int unsigned ResWidth   = 22;

    // result word layout, value in the low bits
    localparam int unsigned ValueLsb = 0;
    localparam int unsigned ValueMsb = 15;
    localparam int unsigned ZeroBit  = 16;
    localparam int unsigned CarryBit = 17;
    localparam int unsigned TagLsb   = 18;
    localparam int unsigned TagMsb   = 21;

    // bit 15 of a command selects the format
    localparam logic FmtAcc = 1'b1;

    typedef logic [5:0]  operand_t;
    typedef logic [12:0] imm_t;

    // shifts use the low 4 bits of operand b, mov passes operand a
    typedef enum logic [2:0] {
        ADD, SUB, AND, OR, XOR, SHL, SHR, MOV
    } arith_op_e;

    typedef enum logic [1:0] {
        ACC_ADD, ACC_LOAD, ACC_READ, ACC_CLEAR
    } acc_op_e;

    typedef struct packed {
        logic      fmt;
        arith_op_e op;
        operand_t  a;
        operand_t  b;
    } arith_cmd_t;

    typedef struct packed {
        logic    fmt;
        acc_op_e op;
        imm_t    imm;
    } acc_cmd_t;

    // both views cover the same 16 bits
    typedef union packed {
        arith_cmd_t arith;
        acc_cmd_t   acc;
    } cmd_word_t;

endpackage

// File: sync_fifo.sv
// Registered circular-buffer FIFO with push/pop strobes and full/empty levels.
// Used for both the command queue and the result queue of the engine.
module sync_fifo #(
    parameter int unsigned DATA_WIDTH = 16,
    parameter int unsigned DEPTH      = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  logic [DATA_WIDTH-1:0]      data_i,
    input  logic                       pop_i,
    output logic                       full_o,
    output logic                       empty_o,
    output logic [$clog2(DEPTH+1)-1:0] usage_o,
    output logic [DATA_WIDTH-1:0]      data_o
);
    localparam int unsigned AddrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CntWidth  = $clog2(DEPTH + 1);
    localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(DEPTH - 1);

    // read and write pointers, wrapping at DEPTH
    logic [AddrWidth-1:0] rd_ptr_q, rd_ptr_d;
    logic [AddrWidth-1:0] wr_ptr_q, wr_ptr_d;
    // fill level, one bit wider than the pointers so full is visible
    logic [CntWidth-1:0]  cnt_q, cnt_d;
    logic                 do_push;
    logic                 do_pop;

    // storage
    logic [DATA_WIDTH-1:0] mem_q [DEPTH];

    assign full_o  = (cnt_q == CntWidth'(DEPTH));
    assign empty_o = (cnt_q == '0);
    assign usage_o = cnt_q;
    assign data_o  = mem_q[rd_ptr_q];

    // requests against the wrong level are dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        if (do_push) begin
            wr_ptr_d = (wr_ptr_q == LastAddr) ? '0 : wr_ptr_q + 1'b1;
        end

        if (do_pop) begin
            rd_ptr_d = (rd_ptr_q == LastAddr) ? '0 : rd_ptr_q + 1'b1;
        end

        // push and pop together leave the level unchanged
        if (do_push && !do_pop) begin
            cnt_d = cnt_q + 1'b1;
        end else if (do_pop && !do_push) begin
            cnt_d = cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // flush empties the queue, stored data is simply abandoned
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // write port, only on an accepted push
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: cmd_decoder.sv
// Decode stage: pops the command FIFO and registers the fields of the selected
// format together with a stage valid bit. Holds its register while stalled.
module cmd_decoder import cmd_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic [CmdWidth-1:0] fifo_data_i,
    input  logic                fifo_empty_i,
    input  logic                stall_i,
    output logic                fifo_pop_o,
    output logic                dec_valid_o,
    output logic                dec_is_acc_o,
    output arith_op_e           dec_arith_op_o,
    output acc_op_e             dec_acc_op_o,
    output operand_t            dec_a_o,
    output operand_t            dec_b_o,
    output imm_t                dec_imm_o
);
    // the FIFO head seen through both command formats
    cmd_word_t cmd;

    assign cmd = fifo_data_i;

    // take the head whenever the stage can move on
    assign fifo_pop_o = ~fifo_empty_i & ~stall_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dec_valid_o <= 1'b0;
        end else if (flush_i) begin
            dec_valid_o <= 1'b0;
        end else if (!stall_i) begin
            // empty FIFO leaves a bubble
            dec_valid_o <= ~fifo_empty_i;
        end
    end

    // decoded fields
    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            dec_is_acc_o <= (cmd.acc.fmt == FmtAcc);
            if (cmd.acc.fmt == FmtAcc) begin
                dec_acc_op_o <= cmd.acc.op;
                dec_imm_o    <= cmd.acc.imm;
            end else begin
                dec_arith_op_o <= cmd.arith.op;
                dec_a_o        <= cmd.arith.a;
                dec_b_o        <= cmd.arith.b;
            end
        end
    end

endmodule

// File: alu_execute.sv
// Execute stage: computes the arithmetic result or updates the accumulator,
// then registers value and carry for the result stage.
module alu_execute import cmd_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  stall_i,
    input  logic                  dec_valid_i,
    input  logic                  dec_is_acc_i,
    input  arith_op_e             dec_arith_op_i,
    input  acc_op_e               dec_acc_op_i,
    input  operand_t              dec_a_i,
    input  operand_t              dec_b_i,
    input  imm_t                  dec_imm_i,
    output logic                  exe_valid_o,
    output logic [ValueWidth-1:0] exe_value_o,
    output logic                  exe_carry_o
);
    // operands widened to the value size
    logic [ValueWidth-1:0] a_ext;
    logic [ValueWidth-1:0] b_ext;
    logic [ValueWidth-1:0] imm_ext;
    // 17 bit sum or difference, top bit is carry or borrow
    logic [ValueWidth:0]   sum_wide;
    logic [ValueWidth-1:0] acc_q, acc_d;
    logic [ValueWidth-1:0] value_d;
    logic                  carry_d;
    logic                  acc_update;

    assign a_ext   = ValueWidth'(dec_a_i);
    assign b_ext   = ValueWidth'(dec_b_i);
    assign imm_ext = ValueWidth'(dec_imm_i);

    // accumulator moves only with a valid acc command that advances
    assign acc_update = dec_valid_i & dec_is_acc_i & ~stall_i & ~flush_i;

    always_comb begin
        acc_d    = acc_q;
        value_d  = '0;
        carry_d  = 1'b0;
        sum_wide = '0;
        if (dec_is_acc_i) begin
            case (dec_acc_op_i)
                ACC_ADD: begin
                    sum_wide = {1'b0, acc_q} + {1'b0, imm_ext};
                    acc_d    = sum_wide[ValueWidth-1:0];
                    carry_d  = sum_wide[ValueWidth];
                end
                ACC_LOAD:  acc_d = imm_ext;
                ACC_CLEAR: acc_d = '0;
                default:   acc_d = acc_q;
            endcase
            // every acc op reports the new accumulator
            value_d = acc_d;
        end else begin
            case (dec_arith_op_i)
                ADD, SUB: begin
                    sum_wide = (dec_arith_op_i == SUB) ? {1'b0, a_ext} - {1'b0, b_ext}
                                                       : {1'b0, a_ext} + {1'b0, b_ext};
                    value_d  = sum_wide[ValueWidth-1:0];
                    carry_d  = sum_wide[ValueWidth];
                end
                AND:     value_d = a_ext & b_ext;
                OR:      value_d = a_ext | b_ext;
                XOR:     value_d = a_ext ^ b_ext;
                SHL:     value_d = a_ext << b_ext[3:0];
                SHR:     value_d = a_ext >> b_ext[3:0];
                default: value_d = a_ext;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            exe_valid_o <= 1'b0;
            acc_q       <= '0;
        end else begin
            if (flush_i) begin
                exe_valid_o <= 1'b0;
            end else if (!stall_i) begin
                exe_valid_o <= dec_valid_i;
            end
            if (acc_update) begin
                acc_q <= acc_d;
            end
        end
    end

    // result payload, held during a stall
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            exe_value_o <= value_d;
            exe_carry_o <= carry_d;
        end
    end

endmodule

// File: result_stage.sv
// Result stage: adds the zero flag, carry and a sequence tag to the value and
// pushes the word into the result FIFO, stalling the pipeline when it is full.
module result_stage import cmd_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  exe_valid_i,
    input  logic [ValueWidth-1:0] exe_value_i,
    input  logic                  exe_carry_i,
    input  logic                  res_full_i,
    output logic                  res_push_o,
    output logic [ResWidth-1:0]   res_word_o,
    output logic                  stall_o
);
    // sequence tag, wraps at 16
    logic [TagWidth-1:0] tag_q;

    assign res_push_o = exe_valid_i & ~res_full_i;
    // a waiting result holds both earlier stages
    assign stall_o    = exe_valid_i & res_full_i;

    // result word fields
    assign res_word_o[ValueMsb:ValueLsb] = exe_value_i;
    assign res_word_o[ZeroBit]           = (exe_value_i == '0);
    assign res_word_o[CarryBit]          = exe_carry_i;
    assign res_word_o[TagMsb:TagLsb]     = tag_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tag_q <= '0;
        end else if (res_push_o) begin
            tag_q <= tag_q + 1'b1;
        end
    end

endmodule

// File: cmd_engine_top.sv
// Command engine top level: command FIFO, decode, execute and result stages,
// and the result FIFO the host pops from.
module cmd_engine_top import cmd_pkg::*; #(
    parameter int unsigned CmdDepth = 4,
    parameter int unsigned ResDepth = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  logic [CmdWidth-1:0]           cmd_i,
    input  logic                          cmd_push_i,
    input  logic                          res_pop_i,
    output logic                          cmd_full_o,
    output logic [ResWidth-1:0]           res_o,
    output logic                          res_empty_o,
    output logic [$clog2(ResDepth+1)-1:0] res_usage_o
);
    // command FIFO to decoder
    logic [CmdWidth-1:0]   cmd_data;
    logic                  cmd_empty;
    logic                  cmd_pop;
    // decoder to execute
    logic                  dec_valid;
    logic                  dec_is_acc;
    arith_op_e             dec_arith_op;
    acc_op_e               dec_acc_op;
    operand_t              dec_a;
    operand_t              dec_b;
    imm_t                  dec_imm;
    // execute to result stage
    logic                  exe_valid;
    logic [ValueWidth-1:0] exe_value;
    logic                  exe_carry;
    // result stage to result FIFO
    logic                  res_push;
    logic [ResWidth-1:0]   res_word;
    logic                  res_full;
    logic                  stall;

    sync_fifo #(
        .DATA_WIDTH (CmdWidth),
        .DEPTH      (CmdDepth)
    ) i_cmd_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .push_i  (cmd_push_i),
        .data_i  (cmd_i),
        .pop_i   (cmd_pop),
        .full_o  (cmd_full_o),
        .empty_o (cmd_empty),
        .usage_o (),
        .data_o  (cmd_data)
    );

    cmd_decoder i_decoder (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .fifo_data_i    (cmd_data),
        .fifo_empty_i   (cmd_empty),
        .stall_i        (stall),
        .fifo_pop_o     (cmd_pop),
        .dec_valid_o    (dec_valid),
        .dec_is_acc_o   (dec_is_acc),
        .dec_arith_op_o (dec_arith_op),
        .dec_acc_op_o   (dec_acc_op),
        .dec_a_o        (dec_a),
        .dec_b_o        (dec_b),
        .dec_imm_o      (dec_imm)
    );

    alu_execute i_execute (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .stall_i        (stall),
        .dec_valid_i    (dec_valid),
        .dec_is_acc_i   (dec_is_acc),
        .dec_arith_op_i (dec_arith_op),
        .dec_acc_op_i   (dec_acc_op),
        .dec_a_i        (dec_a),
        .dec_b_i        (dec_b),
        .dec_imm_i      (dec_imm),
        .exe_valid_o    (exe_valid),
        .exe_value_o    (exe_value),
        .exe_carry_o    (exe_carry)
    );

    result_stage i_result (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .exe_valid_i (exe_valid),
        .exe_value_i (exe_value),
        .exe_carry_i (exe_carry),
        .res_full_i  (res_full),
        .res_push_o  (res_push),
        .res_word_o  (res_word),
        .stall_o     (stall)
    );

    sync_fifo #(
        .DATA_WIDTH (ResWidth),
        .DEPTH      (ResDepth)
    ) i_res_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .push_i  (res_push),
        .data_i  (res_word),
        .pop_i   (res_pop_i),
        .full_o  (res_full),
        .empty_o (res_empty_o),
        .usage_o (res_usage_o),
        .data_o  (res_o)
    );

endmodule

// File: cmd_engine_properties.sv
// FIFO protocol checks, bound into every sync_fifo instance of the engine.
// Covers the push/pop strobes against the full/empty levels and the fill level.
module cmd_engine_properties #(
    parameter int unsigned DEPTH = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  logic                       pop_i,
    input  logic                       full_o,
    input  logic                       empty_o,
    input  logic [$clog2(DEPTH+1)-1:0] usage_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // writers must respect the full level
    push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        full_o |-> !push_i)
        else $error("push strobe while the FIFO is full");

    // readers must respect the empty level
    pop_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        empty_o |-> !pop_i)
        else $error("pop strobe while the FIFO is empty");

    // level moves by one at most, a flush may drop it to zero
    usage_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !flush_i |=> (usage_o == $past(usage_o) || usage_o == $past(usage_o) + 1
                      || usage_o == $past(usage_o) - 1))
        else $error("FIFO fill level jumped by more than one");

    // first edge out of reset sees an empty queue
    reset_empty: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (empty_o && usage_o == '0))
        else $error("FIFO not empty after reset");

endmodule

bind sync_fifo cmd_engine_properties #(.DEPTH(DEPTH)) i_fifo_props (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .push_i  (push_i),
    .pop_i   (pop_i),
    .full_o  (full_o),
    .empty_o (empty_o),
    .usage_o (usage_o)
);

// File: tb_cmd_engine.sv
// Directed testbench for the command engine. Pushes commands on the host side,
// predicts each result word with a software model and checks what is popped.
module tb_cmd_engine import cmd_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned CmdDepth = 4;
    localparam int unsigned ResDepth = 4;
    // cycle budgets of reset, arith, accumulator, latency, back-pressure and flush
    localparam int unsigned WatchdogCycles = 2 * (40 + 200 + 200 + 30 + 120 + 80);

    logic                          clk_i;
    logic                          rst_ni;
    logic                          flush_i;
    logic [CmdWidth-1:0]           cmd_i;
    logic                          cmd_push_i;
    logic                          res_pop_i;
    logic                          cmd_full_o;
    logic [ResWidth-1:0]           res_o;
    logic                          res_empty_o;
    logic [$clog2(ResDepth+1)-1:0] res_usage_o;

    // model copies of accumulator and tag, plus results still to come
    logic [ValueWidth-1:0] model_acc;
    logic [TagWidth-1:0]   model_tag;
    logic [ResWidth-1:0]   exp_q[$];
    string                 test_name;

    cmd_engine_top #(
        .CmdDepth (CmdDepth),
        .ResDepth (ResDepth)
    ) UUT (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .cmd_i       (cmd_i),
        .cmd_push_i  (cmd_push_i),
        .res_pop_i   (res_pop_i),
        .cmd_full_o  (cmd_full_o),
        .res_o       (res_o),
        .res_empty_o (res_empty_o),
        .res_usage_o (res_usage_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input logic [31:0] expected, input logic [31:0] actual);
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
        stop_run();
    endtask

    function automatic logic [CmdWidth-1:0] arith_word(input arith_op_e op, input operand_t a,
                                                       input operand_t b);
        return {1'b0, op, a, b};
    endfunction

    function automatic logic [CmdWidth-1:0] acc_word(input acc_op_e op, input imm_t imm);
        return {1'b1, op, imm};
    endfunction

    // expected result word that also advances the model accumulator and tag
    function automatic logic [ResWidth-1:0] model_result(input logic [CmdWidth-1:0] w);
        logic [ValueWidth-1:0] a;
        logic [ValueWidth-1:0] b;
        logic [ValueWidth-1:0] value;
        logic [ValueWidth:0]   wide;
        logic                  carry;
        a     = {10'b0, w[11:6]};
        b     = {10'b0, w[5:0]};
        carry = 1'b0;
        if (w[15]) begin
            case (acc_op_e'(w[14:13]))
                ACC_ADD: begin
                    wide      = {1'b0, model_acc} + {4'b0, w[12:0]};
                    carry     = wide[16];
                    model_acc = wide[15:0];
                end
                ACC_LOAD:  model_acc = {3'b0, w[12:0]};
                ACC_CLEAR: model_acc = '0;
                default:   model_acc = model_acc;
            endcase
            value = model_acc;
        end else begin
            case (arith_op_e'(w[14:12]))
                ADD: begin
                    wide  = {1'b0, a} + {1'b0, b};
                    value = wide[15:0];
                    carry = wide[16];
                end
                SUB: begin
                    value = a - b;
                    carry = (a < b);
                end
                AND:     value = a & b;
                OR:      value = a | b;
                XOR:     value = a ^ b;
                SHL:     value = a << b[3:0];
                SHR:     value = a >> b[3:0];
                default: value = a;
            endcase
        end
        model_result = {model_tag, carry, (value == '0), value};
        model_tag    = model_tag + 1'b1;
    endfunction

    // one push strobe that the FIFO takes at the second rising edge
    task automatic push_cmd(input logic [CmdWidth-1:0] w);
        @(negedge clk_i);
        assert (!cmd_full_o) else begin
            $display("host push attempted while the command FIFO is full in %s", test_name);
            stop_run();
        end
        @(posedge clk_i);
        cmd_i      <= w;
        cmd_push_i <= 1'b1;
        @(posedge clk_i);
        cmd_push_i <= 1'b0;
        exp_q.push_back(model_result(w));
    endtask

    // wait for a result, compare it with the oldest prediction, then pop it
    task automatic pop_check();
        logic [ResWidth-1:0] expected;
        @(negedge clk_i);
        while (res_empty_o) begin
            @(negedge clk_i);
        end
        assert (exp_q.size() > 0) else begin
            $display("a result appeared that no pushed command accounts for in %s", test_name);
            stop_run();
        end
        expected = exp_q.pop_front();
        assert (res_o === expected) else report_mismatch(32'(expected), 32'(res_o));
        assert (res_usage_o <= ResDepth) else report_mismatch(ResDepth, res_usage_o);
        @(posedge clk_i);
        res_pop_i <= 1'b1;
        @(posedge clk_i);
        res_pop_i <= 1'b0;
    endtask

    task automatic reset_state_test();
        test_name = "reset_state";
        @(negedge clk_i);
        assert (cmd_full_o == 1'b0) else report_mismatch(0, cmd_full_o);
        assert (res_empty_o == 1'b1) else report_mismatch(1, res_empty_o);
        assert (res_usage_o == '0) else report_mismatch(0, res_usage_o);
    endtask

    // two rounds over all eight ops so tags run 0 to 15
    task automatic arith_test();
        test_name = "arith";
        for (int round = 0; round < 2; round++) begin
            for (int op = 0; op < 8; op++) begin
                push_cmd(arith_word(arith_op_e'(op), 6'($urandom), 6'($urandom)));
                pop_check();
            end
        end
    endtask

    // load max imm, then adds until the 16 bit sum wraps on the eighth one
    task automatic accumulator_test();
        test_name = "accumulator";
        push_cmd(acc_word(ACC_LOAD, 13'h1fff));
        pop_check();
        for (int i = 0; i < 8; i++) begin
            push_cmd(acc_word(ACC_ADD, 13'h1fff));
            pop_check();
            if (i % 3 == 0) begin
                push_cmd(arith_word(ADD, 6'($urandom), 6'($urandom)));
                pop_check();
            end
        end
        push_cmd(acc_word(ACC_READ, 13'($urandom)));
        pop_check();
        push_cmd(acc_word(ACC_CLEAR, 13'($urandom)));
        pop_check();
        push_cmd(acc_word(ACC_READ, 13'h0000));
        pop_check();
    endtask

    // result readable after edge k+3 for a push at edge k
    task automatic latency_test();
        test_name = "latency";
        push_cmd(arith_word(MOV, 6'h2a, 6'h00));
        repeat (3) begin
            @(negedge clk_i);
            assert (res_empty_o) else begin
                $display("result visible earlier than three edges after the push");
                stop_run();
            end
        end
        @(negedge clk_i);
        assert (!res_empty_o) else begin
            $display("result not visible three edges after the push");
            stop_run();
        end
        pop_check();
    endtask

    task automatic backpressure_test();
        int unsigned pushes;
        logic        full_seen;
        test_name = "backpressure";
        pushes    = 0;
        full_seen = 1'b0;
        while (!full_seen) begin
            push_cmd(arith_word(arith_op_e'($urandom_range(7)), 6'($urandom), 6'($urandom)));
            pushes++;
            @(negedge clk_i);
            full_seen = cmd_full_o;
            assert (res_usage_o <= ResDepth) else report_mismatch(ResDepth, res_usage_o);
        end
        // spaced pushes leave a bubble in the decode register when the stall begins
        // so the execute register is the only stage holding a command
        assert (pushes == CmdDepth + ResDepth + 1)
            else report_mismatch(CmdDepth + ResDepth + 1, pushes);
        while (exp_q.size() > 0) begin
            pop_check();
        end
        @(negedge clk_i);
        assert (res_empty_o) else report_mismatch(1, res_empty_o);
    endtask

    task automatic flush_test();
        test_name = "flush";
        push_cmd(acc_word(ACC_ADD, 13'h0123));
        push_cmd(arith_word(SUB, 6'h05, 6'h09));
        push_cmd(acc_word(ACC_LOAD, 13'h0abc));
        // all three results land before the flush
        @(negedge clk_i);
        while (res_usage_o != 3) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        exp_q.delete();
        repeat (4) begin
            @(negedge clk_i);
            assert (res_empty_o) else report_mismatch(1, res_empty_o);
        end
        // accumulator and tag carry on from before the flush
        push_cmd(acc_word(ACC_READ, 13'h0000));
        pop_check();
        push_cmd(arith_word(XOR, 6'h3c, 6'h0f));
        pop_check();
    endtask

    initial begin
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        flush_i    = 1'b0;
        cmd_i      = '0;
        cmd_push_i = 1'b0;
        res_pop_i  = 1'b0;
        model_acc  = '0;
        model_tag  = '0;
        void'($urandom(32'hecba));
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        reset_state_test();
        arith_test();
        accumulator_test();
        latency_test();
        backpressure_test();
        flush_test();
        $display("test passed");
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk_i);
        $display("watchdog expired after %0d cycles in %s", WatchdogCycles, test_name);
        stop_run();
    end

endmodule

// File: sources.f
cmd_pkg.sv
sync_fifo.sv
cmd_decoder.sv
alu_execute.sv
result_stage.sv
cmd_engine_top.sv
cmd_engine_properties.sv
tb_cmd_engine.sv
